// File: matrix_ctrl_consts.svh
// ---------------------------------------------------------------------------
// Panel geometry, address widths and command characters of the LED matrix
// controller. Include wherever one of these constants is needed.
// ---------------------------------------------------------------------------
`ifndef MATRIX_CTRL_CONSTS_SVH
`define MATRIX_CTRL_CONSTS_SVH

// 32 x 64 panel, two bytes per pixel
`define MATRIX_ROWS         32
`define MATRIX_COLS         64
`define ROW_BITS            5
`define COL_BITS            6
`define BYTE_SEL_BITS       1
`define RAM_ADDR_BITS       12

`define BRIGHTNESS_LEVELS   6

// single-byte commands
`define CMD_RED_ON          "R"
`define CMD_RED_OFF         "r"
`define CMD_GREEN_ON        "G"
`define CMD_GREEN_OFF       "g"
`define CMD_BLUE_ON         "B"
`define CMD_BLUE_OFF        "b"
`define CMD_PLANES_OFF      "0"
`define CMD_PLANE_FIRST     "1"
`define CMD_PLANES_ON       "9"

// commands with arguments or a sweep
`define CMD_LEVEL           "T"
`define CMD_PIXEL           "P"
`define CMD_BLANK           "Z"
`define CMD_FILL            "F"

`endif

// File: matrix_ctrl_pkg.sv
// ---------------------------------------------------------------------------
// Types shared by the matrix controller blocks: frame RAM address views,
// brightness plane enables and the dispatcher states.
// ---------------------------------------------------------------------------
`default_nettype none

`include "matrix_ctrl_consts.svh"

package matrix_ctrl_pkg;

    // byte_sel 1 holds the high colour byte of a pixel
    typedef struct packed {
        logic [`ROW_BITS-1:0]      row;
        logic [`COL_BITS-1:0]      col;
        logic [`BYTE_SEL_BITS-1:0] byte_sel;
    } ram_addr_fields_t;

    typedef union packed {
        logic [`RAM_ADDR_BITS-1:0] flat;
        ram_addr_fields_t          fields;
    } ram_addr_u;

    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_t;

    typedef enum logic [1:0] {
        idle,
        level,
        pixel,
        fill
    } cmd_state_e;

endpackage

`default_nettype wire

// File: panel_settings.sv
// ---------------------------------------------------------------------------
// Colour enables and brightness bit planes, updated by single-byte commands
// and by the argument of T. Brightness settles one cycle after its pending copy.
// ---------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "matrix_ctrl_consts.svh"

module panel_settings
    import matrix_ctrl_pkg::*;
(
    input  wire         clk_in,
    input  wire         reset,
    input  wire  [7:0]  rx_byte,
    input  wire         cmd_strobe,
    input  wire         level_strobe,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness_enable
);

    brightness_t brightness_pend;
    brightness_t toggle_mask;

    // digit n flips plane BRIGHTNESS_LEVELS-n
    always_comb begin
        toggle_mask = '0;
        for (int n = 1; n <= `BRIGHTNESS_LEVELS; n++) begin
            if (rx_byte == 8'(`CMD_PLANE_FIRST + n - 1)) begin
                toggle_mask[`BRIGHTNESS_LEVELS-n] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rgb_enable        <= 3'b111;
            brightness_pend   <= '1;
            brightness_enable <= '1;
        end else begin
            brightness_enable <= brightness_pend;
            if (level_strobe) begin
                brightness_pend <= rx_byte[`BRIGHTNESS_LEVELS-1:0];
            end else if (cmd_strobe) begin
                case (rx_byte)
                    `CMD_RED_ON:     rgb_enable[0] <= 1'b1;
                    `CMD_RED_OFF:    rgb_enable[0] <= 1'b0;
                    `CMD_GREEN_ON:   rgb_enable[1] <= 1'b1;
                    `CMD_GREEN_OFF:  rgb_enable[1] <= 1'b0;
                    `CMD_BLUE_ON:    rgb_enable[2] <= 1'b1;
                    `CMD_BLUE_OFF:   rgb_enable[2] <= 1'b0;
                    `CMD_PLANES_OFF: brightness_pend <= '0;
                    `CMD_PLANES_ON:  brightness_pend <= '1;
                    // unknown bytes leave the mask empty
                    default:         brightness_pend <= brightness_pend ^ toggle_mask;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: pixel_writer.sv
// ---------------------------------------------------------------------------
// Engine for P: takes row, column, high and low colour bytes, then writes the
// two bytes of that pixel in consecutive cycles, high byte first.
// ---------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "matrix_ctrl_consts.svh"

module pixel_writer
    import matrix_ctrl_pkg::*;
(
    input  wire        clk_in,
    input  wire        reset,
    input  wire  [7:0] rx_byte,
    input  wire        pixel_strobe,
    output logic       pixel_we,
    output ram_addr_u  pixel_addr,
    output logic [7:0] pixel_data,
    output logic       pixel_done
);

    localparam logic [1:0] wr_idle  = 2'd0;
    localparam logic [1:0] wr_armed = 2'd1;
    localparam logic [1:0] wr_high  = 2'd2;
    localparam logic [1:0] wr_low   = 2'd3;

    logic [1:0]           arg_idx;
    logic [1:0]           wr_phase;
    logic [`ROW_BITS-1:0] row_q;
    logic [`COL_BITS-1:0] col_q;
    logic [7:0]           hi_q;
    logic [7:0]           lo_q;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            arg_idx  <= 2'd0;
            wr_phase <= wr_idle;
        end else begin
            if (pixel_strobe) begin
                arg_idx <= arg_idx + 2'd1;
            end
            case (wr_phase)
                wr_idle:  if (pixel_strobe && arg_idx == 2'd3) wr_phase <= wr_armed;
                wr_armed: wr_phase <= wr_high;
                wr_high:  wr_phase <= wr_low;
                default:  wr_phase <= wr_idle;
            endcase
        end
    end

    // argument bytes in arrival order
    always_ff @(posedge clk_in) begin
        if (pixel_strobe) begin
            case (arg_idx)
                2'd0:    row_q <= rx_byte[`ROW_BITS-1:0];
                2'd1:    col_q <= rx_byte[`COL_BITS-1:0];
                2'd2:    hi_q  <= rx_byte;
                default: lo_q  <= rx_byte;
            endcase
        end
    end

    always_comb begin
        pixel_addr = '0;
        pixel_data = 8'd0;
        if (wr_phase[1]) begin
            pixel_addr.fields.row      = row_q;
            pixel_addr.fields.col      = col_q;
            pixel_addr.fields.byte_sel = ~wr_phase[0];
            pixel_data                 = wr_phase[0] ? lo_q : hi_q;
        end
    end

    assign pixel_we   = wr_phase[1];
    assign pixel_done = (wr_phase == wr_low);

    // dispatcher holds off new bytes until the pixel is written
    a_no_strobe_in_write: assert property (@(posedge clk_in) disable iff (reset)
        pixel_strobe |-> (wr_phase == wr_idle));

endmodule

`default_nettype wire

// File: panel_filler.sv
// ---------------------------------------------------------------------------
// Engine for Z and F: sweeps every frame RAM byte once, writing zero for Z
// or the two-byte colour taken from the F arguments.
// ---------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "matrix_ctrl_consts.svh"

module panel_filler
    import matrix_ctrl_pkg::*;
(
    input  wire        clk_in,
    input  wire        reset,
    input  wire  [7:0] rx_byte,
    input  wire        fill_strobe,
    input  wire        blank_start,
    output logic       fill_we,
    output ram_addr_u  fill_addr,
    output logic [7:0] fill_data,
    output logic       fill_done
);

    localparam logic [`RAM_ADDR_BITS-1:0] last_addr =
        `RAM_ADDR_BITS'(`MATRIX_ROWS * `MATRIX_COLS * (1 << `BYTE_SEL_BITS) - 1);

    logic                      sweeping;
    logic [`RAM_ADDR_BITS-1:0] sweep_count;
    logic                      arg_second;
    logic [7:0]                hi_q;
    logic [7:0]                lo_q;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            sweeping    <= 1'b0;
            sweep_count <= '0;
            arg_second  <= 1'b0;
        end else begin
            if (sweeping) begin
                sweep_count <= sweep_count + 1'b1;
                if (sweep_count == last_addr) begin
                    sweeping <= 1'b0;
                end
            end
            if (fill_strobe) begin
                arg_second <= ~arg_second;
            end
            // low colour byte or Z both kick off a sweep from address 0
            if (blank_start || (fill_strobe && arg_second)) begin
                sweeping    <= 1'b1;
                sweep_count <= '0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (blank_start) begin
            hi_q <= 8'd0;
            lo_q <= 8'd0;
        end else if (fill_strobe) begin
            if (arg_second) begin
                lo_q <= rx_byte;
            end else begin
                hi_q <= rx_byte;
            end
        end
    end

    always_comb begin
        fill_addr = '0;
        fill_data = 8'd0;
        if (sweeping) begin
            fill_addr.flat = sweep_count;
            // odd addresses take the high byte
            fill_data = fill_addr.fields.byte_sel[0] ? hi_q : lo_q;
        end
    end

    assign fill_we   = sweeping;
    assign fill_done = sweeping && (sweep_count == last_addr);

    a_no_start_mid_sweep: assert property (@(posedge clk_in) disable iff (reset)
        (blank_start || fill_strobe) |-> !sweeping);

endmodule

`default_nettype wire

// File: cmd_dispatcher.sv
// ---------------------------------------------------------------------------
// Receives bytes from the serial side, tracks the active command and strobes
// the settings block and write engines. The RAM write port follows the state.
// ---------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "matrix_ctrl_consts.svh"

module cmd_dispatcher
    import matrix_ctrl_pkg::*;
(
    input  wire                        clk_in,
    input  wire                        reset,
    input  wire  [7:0]                 data_rx,
    input  wire                        data_ready_n,
    input  wire                        pixel_we,
    input  wire  ram_addr_u            pixel_addr,
    input  wire  [7:0]                 pixel_data,
    input  wire                        pixel_done,
    input  wire                        fill_we,
    input  wire  ram_addr_u            fill_addr,
    input  wire  [7:0]                 fill_data,
    input  wire                        fill_done,
    output logic [7:0]                 rx_byte,
    output logic                       cmd_strobe,
    output logic                       level_strobe,
    output logic                       pixel_strobe,
    output logic                       fill_strobe,
    output logic                       blank_start,
    output logic [`RAM_ADDR_BITS-1:0]  ram_address,
    output logic [7:0]                 ram_data_out,
    output logic                       ram_write_enable,
    output logic                       busy,
    output logic                       ready_for_data
);

    // index of the argument that starts the RAM writes
    localparam logic [1:0] pixel_last_arg = 2'd3;
    localparam logic [1:0] fill_last_arg  = 2'd1;

    cmd_state_e state;
    logic       rx_valid;
    logic       hold;
    logic [1:0] arg_count;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= ~data_ready_n && ready_for_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (~data_ready_n && ready_for_data) begin
            rx_byte <= data_rx;
        end
    end

    assign cmd_strobe   = rx_valid && (state == idle);
    assign level_strobe = rx_valid && (state == level);
    assign pixel_strobe = rx_valid && (state == pixel);
    assign fill_strobe  = rx_valid && (state == fill);
    assign blank_start  = cmd_strobe && (rx_byte == `CMD_BLANK);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state     <= idle;
            hold      <= 1'b0;
            arg_count <= 2'd0;
        end else begin
            case (state)
                idle: begin
                    arg_count <= 2'd0;
                    if (cmd_strobe) begin
                        case (rx_byte)
                            `CMD_LEVEL: state <= level;
                            `CMD_PIXEL: state <= pixel;
                            `CMD_FILL:  state <= fill;
                            `CMD_BLANK: begin
                                state <= fill;
                                hold  <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                level: if (level_strobe) state <= idle;
                pixel: begin
                    if (pixel_strobe) begin
                        arg_count <= arg_count + 2'd1;
                        hold      <= (arg_count == pixel_last_arg);
                    end
                    if (pixel_done) begin
                        state <= idle;
                        hold  <= 1'b0;
                    end
                end
                default: begin
                    if (fill_strobe) begin
                        arg_count <= arg_count + 2'd1;
                        hold      <= (arg_count == fill_last_arg);
                    end
                    if (fill_done) begin
                        state <= idle;
                        hold  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_comb begin
        ram_write_enable = 1'b0;
        ram_address      = '0;
        ram_data_out     = 8'd0;
        case (state)
            pixel: begin
                ram_write_enable = pixel_we;
                ram_address      = pixel_addr.flat;
                ram_data_out     = pixel_data;
            end
            fill: begin
                ram_write_enable = fill_we;
                ram_address      = fill_addr.flat;
                ram_data_out     = fill_data;
            end
            default: ;
        endcase
    end

    assign busy           = (state != idle);
    assign ready_for_data = ~hold;

    a_no_engine_write_idle: assert property (@(posedge clk_in) disable iff (reset)
        (state == idle) |-> !(pixel_we || fill_we));

    a_no_byte_when_held: assert property (@(posedge clk_in) disable iff (reset)
        !data_ready_n |-> ready_for_data);

endmodule

`default_nettype wire

// File: matrix_ctrl_top.sv
// ---------------------------------------------------------------------------
// LED matrix command controller. Bytes come in from a serial receiver and
// the frame RAM write port goes out to an external memory.
// ---------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "matrix_ctrl_consts.svh"

module matrix_ctrl_top
    import matrix_ctrl_pkg::*;
(
    input  wire                        clk_in,
    input  wire                        reset,
    input  wire  [7:0]                 data_rx,
    input  wire                        data_ready_n,
    output logic [2:0]                 rgb_enable,
    output brightness_t                brightness_enable,
    output logic [`RAM_ADDR_BITS-1:0]  ram_address,
    output logic [7:0]                 ram_data_out,
    output logic                       ram_write_enable,
    output logic                       busy,
    output logic                       ready_for_data
);

    logic [7:0] rx_byte;
    logic       cmd_strobe;
    logic       level_strobe;
    logic       pixel_strobe;
    logic       fill_strobe;
    logic       blank_start;
    logic       pixel_we;
    ram_addr_u  pixel_addr;
    logic [7:0] pixel_data;
    logic       pixel_done;
    logic       fill_we;
    ram_addr_u  fill_addr;
    logic [7:0] fill_data;
    logic       fill_done;

    cmd_dispatcher u_dispatcher (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .pixel_we         (pixel_we),
        .pixel_addr       (pixel_addr),
        .pixel_data       (pixel_data),
        .pixel_done       (pixel_done),
        .fill_we          (fill_we),
        .fill_addr        (fill_addr),
        .fill_data        (fill_data),
        .fill_done        (fill_done),
        .rx_byte          (rx_byte),
        .cmd_strobe       (cmd_strobe),
        .level_strobe     (level_strobe),
        .pixel_strobe     (pixel_strobe),
        .fill_strobe      (fill_strobe),
        .blank_start      (blank_start),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable),
        .busy             (busy),
        .ready_for_data   (ready_for_data)
    );

    panel_settings u_settings (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_byte           (rx_byte),
        .cmd_strobe        (cmd_strobe),
        .level_strobe      (level_strobe),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    pixel_writer u_pixel (
        .clk_in       (clk_in),
        .reset        (reset),
        .rx_byte      (rx_byte),
        .pixel_strobe (pixel_strobe),
        .pixel_we     (pixel_we),
        .pixel_addr   (pixel_addr),
        .pixel_data   (pixel_data),
        .pixel_done   (pixel_done)
    );

    panel_filler u_filler (
        .clk_in      (clk_in),
        .reset       (reset),
        .rx_byte     (rx_byte),
        .fill_strobe (fill_strobe),
        .blank_start (blank_start),
        .fill_we     (fill_we),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .fill_done   (fill_done)
    );

endmodule

`default_nettype wire

// File: tb_matrix_ctrl.sv
// ----------------------------------------------------------------------------
// Directed testbench for the LED matrix command controller. Models the frame
// RAM, sends command bytes and checks settings, RAM contents and write counts.
// ----------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "matrix_ctrl_consts.svh"

module tb_matrix_ctrl
    import matrix_ctrl_pkg::*;
();

    localparam int clk_period     = 100;
    localparam int ram_bytes      = 1 << `RAM_ADDR_BITS;
    localparam int traffic_cycles = 400;
    localparam int watchdog_cycles = 2 * (3 * ram_bytes + traffic_cycles);

    logic                      clk_in;
    logic                      reset;
    logic [7:0]                data_rx;
    logic                      data_ready_n;
    logic [2:0]                rgb_enable;
    brightness_t               brightness_enable;
    logic [`RAM_ADDR_BITS-1:0] ram_address;
    logic [7:0]                ram_data_out;
    logic                      ram_write_enable;
    logic                      busy;
    logic                      ready_for_data;

    logic [7:0]  ram [0:ram_bytes-1];
    int          write_count;
    int          ready_writes;
    int          error_count;
    logic [31:0] rng_state;
    brightness_t exp_bright;

    matrix_ctrl_top dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data_out      (ram_data_out),
        .ram_write_enable  (ram_write_enable),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    always #(clk_period / 2) clk_in = ~clk_in;

    // frame RAM model samples writes mid-cycle
    always @(negedge clk_in) begin
        if (ram_write_enable) begin
            ram[ram_address] = ram_data_out;
            write_count = write_count + 1;
            if (ready_for_data) begin
                ready_writes = ready_writes + 1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] fill_pattern(input int addr);
        return 8'(addr ^ (addr >> 5) ^ 32'h3c);
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic step_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step_cycle();
    endtask

    task automatic send_byte(input logic [7:0] value);
        while (!ready_for_data) step_cycle();
        data_rx = value;
        data_ready_n = 1'b0;
        step_cycle();
        data_ready_n = 1'b1;
        step_cycle();
    endtask

    task automatic wait_idle(input string test, input int limit);
        int cycles;
        cycles = 0;
        while (busy && cycles < limit) begin
            step_cycle();
            cycles++;
        end
        if (busy) begin
            $display("%s: controller still busy after %0d cycles", test, limit);
            error_count++;
        end
    endtask

    task automatic check_byte(input string test, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %02h, actual %02h", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_rgb(input string test, input logic [2:0] expected,
                             input logic [2:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %03b, actual %03b", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_brightness(input string test, input brightness_t expected,
                                    input brightness_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %b, actual %b", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(input string test, input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error: %s expected %0d, actual %0d", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %b, actual %b", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic reset_and_colours();
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset ready", 1'b1, ready_for_data);
        check_rgb("reset rgb", 3'b111, rgb_enable);
        check_brightness("reset brightness", '1, brightness_enable);
        send_byte(`CMD_RED_OFF);
        check_rgb("colour r", 3'b110, rgb_enable);
        send_byte(`CMD_GREEN_OFF);
        check_rgb("colour g", 3'b100, rgb_enable);
        send_byte(`CMD_BLUE_OFF);
        check_rgb("colour b", 3'b000, rgb_enable);
        send_byte(`CMD_BLUE_ON);
        check_rgb("colour B", 3'b100, rgb_enable);
        send_byte(`CMD_RED_ON);
        check_rgb("colour R", 3'b101, rgb_enable);
        send_byte(`CMD_GREEN_ON);
        check_rgb("colour G", 3'b111, rgb_enable);
        check_count("colour writes", 0, write_count);
    endtask

    task automatic brightness_digits();
        send_byte(`CMD_PLANES_OFF);
        idle_cycles(2);
        exp_bright = '0;
        check_brightness("digit 0", exp_bright, brightness_enable);
        // digit n flips plane LEVELS-n
        for (int n = 1; n <= `BRIGHTNESS_LEVELS; n++) begin
            send_byte(8'(`CMD_PLANES_OFF + n));
            idle_cycles(2);
            exp_bright[`BRIGHTNESS_LEVELS-n] = ~exp_bright[`BRIGHTNESS_LEVELS-n];
            check_brightness($sformatf("digit %0d", n), exp_bright, brightness_enable);
        end
        send_byte(8'(`CMD_PLANES_OFF + 3));
        idle_cycles(2);
        exp_bright[`BRIGHTNESS_LEVELS-3] = 1'b0;
        check_brightness("digit 3 again", exp_bright, brightness_enable);
        send_byte(`CMD_PLANES_ON);
        idle_cycles(2);
        exp_bright = '1;
        check_brightness("digit 9", exp_bright, brightness_enable);
    endtask

    task automatic level_command();
        logic [31:0] r;
        for (int i = 0; i < 3; i++) begin
            next_random(r);
            send_byte(`CMD_LEVEL);
            check_flag("level busy", 1'b1, busy);
            send_byte(r[7:0]);
            check_flag("level busy after argument", 1'b0, busy);
            idle_cycles(2);
            exp_bright = r[`BRIGHTNESS_LEVELS-1:0];
            check_brightness("level value", exp_bright, brightness_enable);
        end
    endtask

    task automatic pixel_write();
        logic [31:0]          r;
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
        logic [7:0]           hi;
        logic [7:0]           lo;
        int                   start;
        for (int i = 0; i < 2; i++) begin
            next_random(r);
            row = r[`ROW_BITS-1:0];
            col = r[8 +: `COL_BITS];
            hi = r[23:16];
            lo = r[31:24];
            start = write_count;
            send_byte(`CMD_PIXEL);
            send_byte(8'(row));
            send_byte(8'(col));
            send_byte(hi);
            send_byte(lo);
            wait_idle("pixel", 20);
            check_count("pixel writes", 2, write_count - start);
            check_byte("pixel high byte", hi, ram[{row, col, 1'b1}]);
            check_byte("pixel low byte", lo, ram[{row, col, 1'b0}]);
        end
    endtask

    task automatic frame_fill();
        logic [31:0] r;
        logic [7:0]  hi;
        logic [7:0]  lo;
        int          start;
        next_random(r);
        hi = r[7:0];
        lo = r[15:8];
        start = write_count;
        send_byte(`CMD_FILL);
        send_byte(hi);
        send_byte(lo);
        check_flag("fill ready during sweep", 1'b0, ready_for_data);
        check_flag("fill busy during sweep", 1'b1, busy);
        wait_idle("fill", ram_bytes + 16);
        check_flag("fill ready after sweep", 1'b1, ready_for_data);
        check_count("fill writes", ram_bytes, write_count - start);
        check_count("writes while ready", 0, ready_writes);
        for (int a = 0; a < ram_bytes; a++) begin
            check_byte($sformatf("fill addr %0d", a), a[0] ? hi : lo, ram[a]);
        end
    endtask

    task automatic blank_and_unknown();
        int start;
        start = write_count;
        send_byte(`CMD_BLANK);
        check_flag("blank ready during sweep", 1'b0, ready_for_data);
        wait_idle("blank", ram_bytes + 16);
        check_count("blank writes", ram_bytes, write_count - start);
        for (int a = 0; a < ram_bytes; a++) begin
            check_byte($sformatf("blank addr %0d", a), 8'h00, ram[a]);
        end
        // a byte that is no command
        start = write_count;
        send_byte("x");
        idle_cycles(4);
        check_count("unknown writes", 0, write_count - start);
        check_flag("unknown busy", 1'b0, busy);
        check_rgb("unknown rgb", 3'b111, rgb_enable);
        check_brightness("unknown brightness", exp_bright, brightness_enable);
    endtask

    initial begin
        clk_in = 1'b0;
        reset = 1'b1;
        data_rx = 8'd0;
        data_ready_n = 1'b1;
        error_count = 0;
        write_count = 0;
        ready_writes = 0;
        rng_state = 32'h60a7_3bcf;
        exp_bright = '1;
        for (int a = 0; a < ram_bytes; a++) begin
            ram[a] = fill_pattern(a);
        end
        repeat (16) @(posedge clk_in);
        #1;
        reset = 1'b0;
        step_cycle();
        reset_and_colours();
        brightness_digits();
        level_command();
        pixel_write();
        frame_fill();
        blank_and_unknown();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
matrix_ctrl_pkg.sv
panel_settings.sv
pixel_writer.sv
panel_filler.sv
cmd_dispatcher.sv
matrix_ctrl_top.sv
tb_matrix_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_matrix_ctrl
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Testbench failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
